// ==== icache_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache configuration package.
// Fixed address, line and id widths, default geometry and the tag entry.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package icache_cfg_pkg;

    // Fetch address and payload widths.
    localparam int unsigned FETCH_AW   = 16;
    localparam int unsigned LINE_WIDTH = 64;
    localparam int unsigned LINE_ALIGN = 3;
    localparam int unsigned ID_WIDTH   = 4;

    // Default cache geometry.
    localparam int unsigned DEFAULT_SET_COUNT  = 2;
    localparam int unsigned DEFAULT_LINE_COUNT = 16;

    // Width of a line address.
    localparam int unsigned LINE_ADDR_W = FETCH_AW - LINE_ALIGN;

    // Tag field sized for the smallest index of one bit.
    localparam int unsigned MAX_TAG_W = LINE_ADDR_W - 1;

    // Width of a way number.
    localparam int unsigned SET_IDX_W = $clog2(DEFAULT_SET_COUNT);

    // One entry of a tag RAM, unused upper tag bits stay zero.
    typedef struct packed {
        logic                 valid;
        logic                 error;
        logic [MAX_TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

// ==== icache_if_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache interface package.
// Payloads of the fetch, lookup, refill and memory channels.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package icache_if_pkg;

    typedef struct packed {
        logic [icache_cfg_pkg::FETCH_AW-1:0] addr;
        logic [icache_cfg_pkg::ID_WIDTH-1:0] id;
    } fetch_req_t;

    // Hit is set when the response needed no refill.
    typedef struct packed {
        logic [icache_cfg_pkg::FETCH_AW-1:0]   addr;
        logic [icache_cfg_pkg::ID_WIDTH-1:0]   id;
        logic [icache_cfg_pkg::LINE_WIDTH-1:0] data;
        logic                                  error;
        logic                                  hit;
    } fetch_rsp_t;

    typedef struct packed {
        logic [icache_cfg_pkg::FETCH_AW-1:0]   addr;
        logic [icache_cfg_pkg::ID_WIDTH-1:0]   id;
        logic [icache_cfg_pkg::LINE_WIDTH-1:0] data;
        logic                                  error;
        logic                                  hit;
        logic [icache_cfg_pkg::SET_IDX_W-1:0]  set;
    } lookup_rsp_t;

    // Index upper bits above the local index width stay zero.
    typedef struct packed {
        logic [icache_cfg_pkg::LINE_ADDR_W-1:0] index;
        logic [icache_cfg_pkg::SET_IDX_W-1:0]   set;
        logic [icache_cfg_pkg::MAX_TAG_W-1:0]   tag;
        logic [icache_cfg_pkg::LINE_WIDTH-1:0]  data;
        logic                                   error;
    } refill_wr_t;

    typedef struct packed {
        logic [icache_cfg_pkg::LINE_ADDR_W-1:0] line_addr;
    } mem_req_t;

    typedef struct packed {
        logic [icache_cfg_pkg::LINE_WIDTH-1:0] data;
        logic                                  error;
    } mem_rsp_t;

endpackage

// ==== icache_lookup.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Cache lookup stage.
// Init and flush sweep, RAM port multiplexer, tag and data RAMs per way,
// tag compare and hit data selection.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module icache_lookup #(
    parameter int unsigned SET_COUNT  = icache_cfg_pkg::DEFAULT_SET_COUNT,
    parameter int unsigned LINE_COUNT = icache_cfg_pkg::DEFAULT_LINE_COUNT
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_valid_i,
    output logic                       flush_ready_o,
    input  icache_if_pkg::fetch_req_t  req_i,
    input  logic                       req_valid_i,
    output logic                       req_ready_o,
    output icache_if_pkg::lookup_rsp_t rsp_o,
    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i,
    input  icache_if_pkg::refill_wr_t  wr_i,
    input  logic                       wr_valid_i,
    output logic                       wr_ready_o
);

    localparam int unsigned INDEX_W = $clog2(LINE_COUNT);
    localparam int unsigned TAG_W   = icache_cfg_pkg::LINE_ADDR_W - INDEX_W;

    logic [INDEX_W:0]                       init_cnt_q;
    logic                                   sweeping;
    logic                                   flush_pend_q;
    logic [INDEX_W-1:0]                     ram_addr;
    logic [SET_COUNT-1:0]                   ram_en;
    logic                                   ram_we;
    logic                                   ram_we_q;
    icache_cfg_pkg::tag_entry_t             ram_wtag;
    icache_cfg_pkg::tag_entry_t             ram_rtag [SET_COUNT];
    logic [icache_cfg_pkg::LINE_WIDTH-1:0]  ram_rdata [SET_COUNT];
    logic                                   accept;
    logic                                   valid_q;
    icache_if_pkg::fetch_req_t              req_q;
    logic [icache_cfg_pkg::MAX_TAG_W-1:0]   req_tag;
    logic [SET_COUNT-1:0]                   line_hit;

    assign sweeping = init_cnt_q != (INDEX_W + 1)'(LINE_COUNT);

    // A flush starts the sweep and is acknowledged once the sweep is done.
    assign flush_ready_o = flush_valid_i & flush_pend_q & ~sweeping;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_cnt_q   <= '0;
            flush_pend_q <= 1'b0;
        end else if (flush_valid_i && !flush_pend_q && !sweeping) begin
            init_cnt_q   <= '0;
            flush_pend_q <= 1'b1;
        end else if (sweeping) begin
            init_cnt_q <= init_cnt_q + 1'b1;
        end else if (flush_ready_o) begin
            flush_pend_q <= 1'b0;
        end
    end

    // One RAM port shared by sweep, refill write and lookup, in that order.
    // A miss waiting in the output register blocks new lookups.
    always_comb begin
        ram_addr    = req_i.addr[icache_cfg_pkg::LINE_ALIGN +: INDEX_W];
        ram_en      = '0;
        ram_we      = 1'b0;
        ram_wtag    = '{valid: 1'b1, error: wr_i.error, tag: wr_i.tag};
        wr_ready_o  = 1'b0;
        req_ready_o = 1'b0;
        if (sweeping) begin
            ram_addr = init_cnt_q[INDEX_W-1:0];
            ram_en   = '1;
            ram_we   = 1'b1;
            ram_wtag = '0;
        end else if (wr_valid_i) begin
            ram_addr   = wr_i.index[INDEX_W-1:0];
            ram_en     = SET_COUNT'(1) << wr_i.set;
            ram_we     = 1'b1;
            wr_ready_o = 1'b1;
        end else if (rsp_ready_i && !(valid_q && !rsp_o.hit)) begin
            ram_en      = {SET_COUNT{req_valid_i}};
            req_ready_o = 1'b1;
        end
    end

    assign accept = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            ram_we_q <= 1'b0;
        end else begin
            ram_we_q <= ram_we;
            if (accept || rsp_ready_i) begin
                valid_q <= accept;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    for (genvar i = 0; i < SET_COUNT; i++) begin : g_way
        icache_sram #(
            .NUM_WORDS (LINE_COUNT),
            .word_t    (icache_cfg_pkg::tag_entry_t)
        ) u_tag_ram (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (ram_en[i]),
            .we_i    (ram_we),
            .addr_i  (ram_addr),
            .wdata_i (ram_wtag),
            .rdata_o (ram_rtag[i])
        );

        // Sweep writes need no zero data, the cleared tag makes the line unused.
        icache_sram #(
            .NUM_WORDS (LINE_COUNT),
            .word_t    (logic [icache_cfg_pkg::LINE_WIDTH-1:0])
        ) u_data_ram (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .req_i   (ram_en[i]),
            .we_i    (ram_we),
            .addr_i  (ram_addr),
            .wdata_i (wr_i.data),
            .rdata_o (ram_rdata[i])
        );
    end

    assign req_tag = icache_cfg_pkg::MAX_TAG_W'(req_q.addr[icache_cfg_pkg::FETCH_AW-1 -: TAG_W]);

    // Tag compare and AND-OR selection of the hit way.
    always_comb begin
        rsp_o.addr  = req_q.addr;
        rsp_o.id    = req_q.id;
        rsp_o.data  = '0;
        rsp_o.error = 1'b0;
        rsp_o.set   = '0;
        for (int i = 0; i < SET_COUNT; i++) begin
            line_hit[i] = ram_rtag[i].valid && (ram_rtag[i].tag == req_tag);
            rsp_o.data  = rsp_o.data | (ram_rdata[i] & {icache_cfg_pkg::LINE_WIDTH{line_hit[i]}});
            rsp_o.error = rsp_o.error | (ram_rtag[i].error & line_hit[i]);
            if (line_hit[i]) begin
                rsp_o.set = icache_cfg_pkg::SET_IDX_W'(i);
            end
        end
        // Read data right after a write belongs to the write, not a lookup.
        rsp_o.hit = |line_hit & ~ram_we_q;
    end

    assign rsp_valid_o = valid_q;

endmodule

// ==== icache_miss_handler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Miss handler.
// Forwards hits, refills missed lines from memory, round-robin victim way.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module icache_miss_handler #(
    parameter int unsigned SET_COUNT  = icache_cfg_pkg::DEFAULT_SET_COUNT,
    parameter int unsigned LINE_COUNT = icache_cfg_pkg::DEFAULT_LINE_COUNT
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  icache_if_pkg::lookup_rsp_t lk_i,
    input  logic                       lk_valid_i,
    output logic                       lk_ready_o,
    output icache_if_pkg::refill_wr_t  wr_o,
    output logic                       wr_valid_o,
    input  logic                       wr_ready_i,
    output icache_if_pkg::mem_req_t    mem_req_o,
    output logic                       mem_req_valid_o,
    input  logic                       mem_req_ready_i,
    input  icache_if_pkg::mem_rsp_t    mem_rsp_i,
    input  logic                       mem_rsp_valid_i,
    output logic                       mem_rsp_ready_o,
    output icache_if_pkg::fetch_rsp_t  rsp_o,
    output logic                       rsp_valid_o,
    input  logic                       rsp_ready_i
);

    localparam int unsigned INDEX_W = $clog2(LINE_COUNT);
    localparam int unsigned TAG_W   = icache_cfg_pkg::LINE_ADDR_W - INDEX_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_WRITE
    } state_e;

    state_e                                 state_q;
    logic                                   wr_done_q;
    logic [icache_cfg_pkg::SET_IDX_W-1:0]   victim_q;
    icache_if_pkg::fetch_req_t              miss_q;
    icache_if_pkg::mem_rsp_t                line_q;
    logic [icache_cfg_pkg::LINE_ADDR_W-1:0] line_addr;

    assign line_addr = miss_q.addr[icache_cfg_pkg::FETCH_AW-1:icache_cfg_pkg::LINE_ALIGN];

    assign mem_req_o.line_addr = line_addr;
    assign mem_req_valid_o     = state_q == ST_REQ;
    assign mem_rsp_ready_o     = state_q == ST_WAIT;

    assign wr_o.index = icache_cfg_pkg::LINE_ADDR_W'(line_addr[INDEX_W-1:0]);
    assign wr_o.set   = victim_q;
    assign wr_o.tag   = icache_cfg_pkg::MAX_TAG_W'(line_addr[icache_cfg_pkg::LINE_ADDR_W-1 -: TAG_W]);
    assign wr_o.data  = line_q.data;
    assign wr_o.error = line_q.error;
    assign wr_valid_o = (state_q == ST_WRITE) & ~wr_done_q;

    // Hits pass straight through; a refilled line answers once written.
    always_comb begin
        if (state_q == ST_IDLE) begin
            rsp_o       = '{addr: lk_i.addr, id: lk_i.id, data: lk_i.data,
                            error: lk_i.error, hit: 1'b1};
            rsp_valid_o = lk_valid_i & lk_i.hit;
            lk_ready_o  = ~lk_valid_i | ~lk_i.hit | rsp_ready_i;
        end else begin
            rsp_o       = '{addr: miss_q.addr, id: miss_q.id, data: line_q.data,
                            error: line_q.error, hit: 1'b0};
            rsp_valid_o = (state_q == ST_WRITE) & wr_done_q;
            lk_ready_o  = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= ST_IDLE;
            wr_done_q <= 1'b0;
            victim_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (lk_valid_i && !lk_i.hit) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (mem_req_ready_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (mem_rsp_valid_i) begin
                        state_q   <= ST_WRITE;
                        wr_done_q <= 1'b0;
                    end
                end
                default: begin
                    if (wr_valid_o && wr_ready_i) begin
                        wr_done_q <= 1'b1;
                        victim_q  <= (victim_q == icache_cfg_pkg::SET_IDX_W'(SET_COUNT - 1)) ?
                                     '0 : victim_q + 1'b1;
                    end
                    if (rsp_valid_o && rsp_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && lk_valid_i && !lk_i.hit) begin
            miss_q <= '{addr: lk_i.addr, id: lk_i.id};
        end
        if (mem_rsp_valid_i && mem_rsp_ready_o) begin
            line_q <= mem_rsp_i;
        end
    end

endmodule

// ==== icache_sram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port synchronous RAM with registered, write-first read data.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module icache_sram #(
    parameter int unsigned NUM_WORDS = 16,
    parameter type         word_t    = logic
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_WORDS)-1:0] addr_i,
    input  word_t                        wdata_i,
    output word_t                        rdata_o
);

    word_t mem_q [NUM_WORDS];

    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
    end

    // Read data only changes on an access.
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (req_i) begin
            rdata_o <= we_i ? wdata_i : mem_q[addr_i];
        end
    end

endmodule

// ==== icache_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache top level.
// Lookup stage and miss handler wired to the fetch and memory ports.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module icache_top #(
    parameter int unsigned SET_COUNT  = icache_cfg_pkg::DEFAULT_SET_COUNT,
    parameter int unsigned LINE_COUNT = icache_cfg_pkg::DEFAULT_LINE_COUNT
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_valid_i,
    output logic                      flush_ready_o,
    input  icache_if_pkg::fetch_req_t fetch_req_i,
    input  logic                      fetch_req_valid_i,
    output logic                      fetch_req_ready_o,
    output icache_if_pkg::fetch_rsp_t fetch_rsp_o,
    output logic                      fetch_rsp_valid_o,
    input  logic                      fetch_rsp_ready_i,
    output icache_if_pkg::mem_req_t   mem_req_o,
    output logic                      mem_req_valid_o,
    input  logic                      mem_req_ready_i,
    input  icache_if_pkg::mem_rsp_t   mem_rsp_i,
    input  logic                      mem_rsp_valid_i,
    output logic                      mem_rsp_ready_o
);

    icache_if_pkg::lookup_rsp_t lk_rsp;
    logic                       lk_valid;
    logic                       lk_ready;
    icache_if_pkg::refill_wr_t  refill;
    logic                       refill_valid;
    logic                       refill_ready;

    icache_lookup #(
        .SET_COUNT  (SET_COUNT),
        .LINE_COUNT (LINE_COUNT)
    ) u_lookup (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_valid_i (flush_valid_i),
        .flush_ready_o (flush_ready_o),
        .req_i         (fetch_req_i),
        .req_valid_i   (fetch_req_valid_i),
        .req_ready_o   (fetch_req_ready_o),
        .rsp_o         (lk_rsp),
        .rsp_valid_o   (lk_valid),
        .rsp_ready_i   (lk_ready),
        .wr_i          (refill),
        .wr_valid_i    (refill_valid),
        .wr_ready_o    (refill_ready)
    );

    icache_miss_handler #(
        .SET_COUNT  (SET_COUNT),
        .LINE_COUNT (LINE_COUNT)
    ) u_miss_handler (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .lk_i            (lk_rsp),
        .lk_valid_i      (lk_valid),
        .lk_ready_o      (lk_ready),
        .wr_o            (refill),
        .wr_valid_o      (refill_valid),
        .wr_ready_i      (refill_ready),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .rsp_o           (fetch_rsp_o),
        .rsp_valid_o     (fetch_rsp_valid_o),
        .rsp_ready_i     (fetch_rsp_ready_i)
    );

endmodule

// ==== list.f ====
icache_cfg_pkg.sv
icache_if_pkg.sv
icache_sram.sv
icache_lookup.sv
icache_miss_handler.sv
icache_top.sv
tb_clock_gen.sv
tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the instruction cache testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_icache \
    --Mdir obj_dir -o tb_icache_sim

./obj_dir/tb_icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and active-low reset generator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_clock_gen #(
    parameter int unsigned PERIOD     = 20,
    parameter int unsigned RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset is released on a falling edge, away from the active edge.
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// ==== tb_icache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction cache testbench.
// Random fetch stimulus, memory model, cache model, checks and reporting.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_icache;

    localparam int SETS      = icache_cfg_pkg::DEFAULT_SET_COUNT;
    localparam int LINES     = icache_cfg_pkg::DEFAULT_LINE_COUNT;
    localparam int NUM_LINES = 48;
    localparam int MAX_CYCLES = 20000;

    typedef struct packed {
        logic [15:0] addr;
        logic [3:0]  id;
        logic        hit;
    } exp_t;

    logic clk;
    logic rst_n;
    logic flush_valid;
    logic flush_ready;
    icache_if_pkg::fetch_req_t fetch_req;
    logic fetch_req_valid;
    logic fetch_req_ready;
    icache_if_pkg::fetch_rsp_t fetch_rsp;
    logic fetch_rsp_valid;
    logic fetch_rsp_ready;
    icache_if_pkg::mem_req_t mem_req;
    logic mem_req_valid;
    logic mem_req_ready;
    icache_if_pkg::mem_rsp_t mem_rsp;
    logic mem_rsp_valid;
    logic mem_rsp_ready;

    // Handshakes seen just before the coming rising edge.
    logic fetch_fire;
    logic rsp_fire;
    logic mreq_fire;
    logic mrsp_fire;
    logic flush_fire;
    icache_if_pkg::fetch_rsp_t rsp_cap;
    logic [12:0] mreq_cap;

    icache_if_pkg::fetch_req_t fetch_q[$];
    exp_t        exp_q[$];
    logic [12:0] miss_q[$];

    // Cache model per way and index.
    logic        model_v    [SETS][LINES];
    logic [12:0] model_line [SETS][LINES];
    int          model_victim;

    // Memory model state.
    logic        mem_busy;
    logic [12:0] mem_line;
    int          acc_wait;
    int          rsp_wait;

    logic [15:0] lfsr_q;
    int          err_cnt;
    int          fail_tests;
    int          test_cnt;
    int          rsp_miss_cnt;
    int          rsp_hit_cnt;
    int          cycle_cnt;
    logic        seen [NUM_LINES];

    tb_clock_gen #(.PERIOD(20), .RST_CYCLES(4)) u_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    icache_top #(
        .SET_COUNT  (SETS),
        .LINE_COUNT (LINES)
    ) u_icache_top (
        .clk_i             (clk),
        .rst_ni            (rst_n),
        .flush_valid_i     (flush_valid),
        .flush_ready_o     (flush_ready),
        .fetch_req_i       (fetch_req),
        .fetch_req_valid_i (fetch_req_valid),
        .fetch_req_ready_o (fetch_req_ready),
        .fetch_rsp_o       (fetch_rsp),
        .fetch_rsp_valid_o (fetch_rsp_valid),
        .fetch_rsp_ready_i (fetch_rsp_ready),
        .mem_req_o         (mem_req),
        .mem_req_valid_o   (mem_req_valid),
        .mem_req_ready_i   (mem_req_ready),
        .mem_rsp_i         (mem_rsp),
        .mem_rsp_valid_i   (mem_rsp_valid),
        .mem_rsp_ready_o   (mem_rsp_ready)
    );

    // Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic next_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            r = (r << 1) | int'(next_bit());
        end
        return r;
    endfunction

    // Line address in four lanes, each XORed with its lane number.
    function automatic logic [63:0] line_data(logic [12:0] la);
        logic [63:0] d;
        for (int i = 0; i < 4; i++) begin
            d[16*i +: 16] = {3'b000, la} ^ 16'(i);
        end
        return d;
    endfunction

    function automatic logic line_error(logic [12:0] la);
        return (la % 7) == 3;
    endfunction

    task automatic report_mismatch(string field, logic [63:0] got, logic [63:0] exp);
        err_cnt++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, field, got, exp);
    endtask

    task automatic report_error(string msg);
        err_cnt++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic process_accept();
        icache_if_pkg::fetch_req_t req;
        logic [12:0] la;
        logic [3:0]  idx;
        logic        hit;
        req = fetch_q.pop_front();
        la  = req.addr[15:3];
        idx = la[3:0];
        hit = 1'b0;
        for (int w = 0; w < SETS; w++) begin
            if (model_v[w][idx] && model_line[w][idx] == la) begin
                hit = 1'b1;
            end
        end
        exp_q.push_back('{addr: req.addr, id: req.id, hit: hit});
        if (!hit) begin
            miss_q.push_back(la);
            model_v[model_victim][idx]    = 1'b1;
            model_line[model_victim][idx] = la;
            model_victim = (model_victim + 1) % SETS;
        end
    endtask

    task automatic check_response(icache_if_pkg::fetch_rsp_t rsp);
        exp_t        e;
        logic [12:0] la;
        if (exp_q.size() == 0) begin
            report_error("fetch response received with no fetch outstanding");
        end else begin
            e  = exp_q.pop_front();
            la = e.addr[15:3];
            if (rsp.addr != e.addr) report_mismatch("addr", 64'(rsp.addr), 64'(e.addr));
            if (rsp.id != e.id) report_mismatch("id", 64'(rsp.id), 64'(e.id));
            if (rsp.hit != e.hit) report_mismatch("hit", 64'(rsp.hit), 64'(e.hit));
            if (rsp.data != line_data(la)) report_mismatch("data", rsp.data, line_data(la));
            if (rsp.error != line_error(la)) begin
                report_mismatch("error", 64'(rsp.error), 64'(line_error(la)));
            end
            if (rsp.hit) rsp_hit_cnt++;
            else rsp_miss_cnt++;
        end
    endtask

    // One clock cycle handles the last edge, drives inputs and samples handshakes.
    task automatic step_cycle();
        @(negedge clk);
        if (fetch_fire) process_accept();
        if (rsp_fire) check_response(rsp_cap);
        if (mreq_fire) begin
            if (miss_q.size() == 0) begin
                report_error("memory request issued for a fetch predicted as a hit");
            end else if (mreq_cap != miss_q[0]) begin
                report_mismatch("line_addr", 64'(mreq_cap), 64'(miss_q[0]));
                void'(miss_q.pop_front());
            end else begin
                void'(miss_q.pop_front());
            end
            mem_busy = 1'b1;
            mem_line = mreq_cap;
            acc_wait = rand_bits(2);
            rsp_wait = rand_bits(2);
        end
        if (mrsp_fire) begin
            mem_busy      = 1'b0;
            mem_rsp_valid = 1'b0;
        end
        if (flush_fire) begin
            flush_valid = 1'b0;
            for (int w = 0; w < SETS; w++) begin
                for (int i = 0; i < LINES; i++) begin
                    model_v[w][i] = 1'b0;
                end
            end
        end

        fetch_req_valid = fetch_q.size() != 0;
        if (fetch_q.size() != 0) fetch_req = fetch_q[0];
        fetch_rsp_ready = rand_bits(2) != 0;
        if (mem_busy) begin
            mem_req_ready = 1'b0;
            if (!mem_rsp_valid) begin
                if (rsp_wait == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp       = '{data: line_data(mem_line), error: line_error(mem_line)};
                end else begin
                    rsp_wait--;
                end
            end
        end else if (mem_req_valid && acc_wait == 0) begin
            mem_req_ready = 1'b1;
        end else begin
            mem_req_ready = 1'b0;
            if (mem_req_valid) acc_wait--;
        end

        #1;
        fetch_fire = fetch_req_valid & fetch_req_ready;
        rsp_fire   = fetch_rsp_valid & fetch_rsp_ready;
        mreq_fire  = mem_req_valid & mem_req_ready;
        mrsp_fire  = mem_rsp_valid & mem_rsp_ready;
        flush_fire = flush_valid & flush_ready;
        rsp_cap    = fetch_rsp;
        mreq_cap   = mem_req.line_addr;
    endtask

    task automatic drain();
        while (fetch_q.size() != 0 || exp_q.size() != 0 || mem_busy || fetch_fire) begin
            step_cycle();
        end
    endtask

    task automatic push_fetch(int k);
        icache_if_pkg::fetch_req_t req;
        req.addr = {13'(k * 3 + 1), 3'(rand_bits(3))};
        req.id   = 4'(rand_bits(4));
        fetch_q.push_back(req);
    endtask

    task automatic finish_test(string name, int err_start);
        test_cnt++;
        if (err_cnt != err_start) begin
            fail_tests++;
            $display("test %s: failed with %0d errors", name, err_cnt - err_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int err_start;
        int wait_cnt;
        int k;
        int pushed;
        int miss_start;
        flush_valid     = 1'b0;
        fetch_req       = '0;
        fetch_req_valid = 1'b0;
        fetch_rsp_ready = 1'b0;
        mem_req_ready   = 1'b0;
        mem_rsp         = '0;
        mem_rsp_valid   = 1'b0;
        {fetch_fire, rsp_fire, mreq_fire, mrsp_fire, flush_fire} = '0;
        lfsr_q = 16'd53;
        {err_cnt, fail_tests, test_cnt, rsp_miss_cnt, rsp_hit_cnt} = '0;
        mem_busy = 1'b0;
        acc_wait = 0;
        rsp_wait = 0;
        model_victim = 0;
        for (int w = 0; w < SETS; w++) begin
            for (int i = 0; i < LINES; i++) begin
                model_v[w][i] = 1'b0;
            end
        end
        for (int i = 0; i < NUM_LINES; i++) seen[i] = 1'b0;
        wait (rst_n);

        // Test 1 checks the reset state and the init sweep.
        err_start = err_cnt;
        if (fetch_rsp_valid || mem_req_valid || fetch_req_ready || flush_ready) begin
            report_error("outputs not low after reset");
        end
        push_fetch(5);
        seen[5]  = 1'b1;
        wait_cnt = 0;
        step_cycle();
        while (!fetch_fire) begin
            wait_cnt++;
            step_cycle();
        end
        if (wait_cnt < LINES - 1) begin
            report_error("fetch accepted before the init sweep ended");
        end
        drain();
        if (rsp_miss_cnt != 1) report_error("first fetch after reset did not miss");
        finish_test("reset_sweep", err_start);

        // Test 2 runs random fetches under back-pressure.
        err_start = err_cnt;
        for (int n = 0; n < 300; n++) begin
            k = rand_bits(6) % NUM_LINES;
            seen[k] = 1'b1;
            push_fetch(k);
        end
        drain();
        if (rsp_hit_cnt + rsp_miss_cnt != 301) report_error("response count is not 301");
        if (rsp_hit_cnt == 0) report_error("no hits seen in random fetches");
        finish_test("random_fetch", err_start);

        // Test 3 checks the flush handshake and the length of its sweep.
        err_start = err_cnt;
        @(negedge clk);
        flush_valid = 1'b1;
        wait_cnt    = 0;
        step_cycle();
        while (!flush_fire) begin
            wait_cnt++;
            step_cycle();
        end
        if (wait_cnt < LINES) begin
            report_error("flush ready came before the flush sweep ended");
        end
        step_cycle();
        finish_test("flush", err_start);

        // Test 4 expects every line fetched before the flush to miss again.
        err_start  = err_cnt;
        miss_start = rsp_miss_cnt;
        pushed     = 0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (seen[i]) begin
                push_fetch(i);
                pushed++;
            end
        end
        drain();
        if (rsp_miss_cnt - miss_start != pushed) begin
            report_error("a line fetched before the flush hit after it");
        end
        finish_test("refetch_after_flush", err_start);

        $display("tests %0d, failed tests %0d, errors %0d", test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
